// ==== files.f ====
+incdir+.
permPkg.sv
delayLine.sv
batchCounter.sv
variableSwapper.sv
pcoeffAccumulator.sv
batchController.sv
permutationPipeline.sv
tbChecker.sv
tbPermutationPipeline.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f files.f --top-module tbPermutationPipeline -o simPermPipe
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simPermPipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== tbPermutationPipeline.sv ====
`timescale 1ns/100ps

`include "permPipe_defs.svh"

module tbPermutationPipeline
    import permPkg::*;
();

    localparam int entryCount = 37;

    logic        clk = 1'b0;
    logic        reset;
    botT         bot;
    botT         top;
    logic        botReq;
    logic        botAck;
    logic        resultReq;
    logic        resultAck;
    pcoeffSumT   pcoeffSum;
    pcoeffCountT pcoeffCount;
    int          errorCount;
    int          resultCount;

    botT         tableBot [entryCount];
    botT         tableTop [entryCount];
    int          tableAckDelay [entryCount];
    pcoeffSumT   tableSum [entryCount];
    pcoeffCountT tableCount [entryCount];
    logic [31:0] lfsrState = 32'd93441;
    int          cycleCount = 0;
    int          timeoutLimit = 100000;

    permutationPipeline dut_i (.*);

    tbChecker checker_i (.*);

    initial forever #50 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        logic feedback;
        feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], feedback};
    endfunction

    task automatic takeBits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
    endtask

    // Walks all six orders of x1..x3 with x0 fixed
    task automatic referenceModel(input botT b, input botT t,
                                  output pcoeffSumT sum, output pcoeffCountT count);
        int   order [6][3];
        int   x [4];
        int   gap;
        int   gapTotal;
        int   validTotal;
        logic valid;
        botT  pb;
        order = '{'{1, 2, 3}, '{1, 3, 2}, '{2, 1, 3}, '{2, 3, 1}, '{3, 1, 2}, '{3, 2, 1}};
        gapTotal = 0;
        validTotal = 0;
        for (int k = 0; k < `PERM_COUNT; k++) begin
            for (int i = 0; i < `BOT_WIDTH; i++) begin
                for (int v = 0; v < 4; v++) begin
                    x[v] = (i >> v) & 1;
                end
                pb[i] = b[4'(x[0] + 2 * x[order[k][0]] + 4 * x[order[k][1]]
                    + 8 * x[order[k][2]])];
            end
            valid = 1'b1;
            gap = 0;
            for (int i = 0; i < `BOT_WIDTH; i++) begin
                if (pb[i] && !t[i]) valid = 1'b0;
                if (t[i] && !pb[i]) gap++;
            end
            if (valid) begin
                gapTotal += gap;
                validTotal++;
            end
        end
        sum = pcoeffSumT'(gapTotal);
        count = pcoeffCountT'(validTotal);
    endtask

    task automatic setEntry(input int n, input botT b, input botT t, input int ackDelay);
        tableBot[n] = b;
        tableTop[n] = t;
        tableAckDelay[n] = ackDelay;
        referenceModel(b, t, tableSum[n], tableCount[n]);
    endtask

    // Raises the request for entry n, called on a falling edge
    task automatic offerEntry(input int n);
        checker_i.expectResult(tableSum[n], tableCount[n]);
        bot = tableBot[n];
        top = tableTop[n];
        botReq = 1'b1;
    endtask

    // Entry n is already offered, called on a falling edge, returns on a falling edge
    task automatic applyEntry(input int n);
        do @(negedge clk); while (!botAck);
        botReq = 1'b0;
        // Operands are free to change once the request is withdrawn
        bot = ~tableBot[n];
        top = ~tableTop[n];
        while (!resultReq) @(negedge clk);
        // Next bot waits on the input side while the result is still held
        if (n + 1 < entryCount) begin
            offerEntry(n + 1);
        end
        repeat (tableAckDelay[n]) @(negedge clk);
        resultAck = 1'b1;
        do @(negedge clk); while (resultReq);
        resultAck = 1'b0;
    endtask

    initial begin
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] r3;
        logic [15:0] r4;
        int          maxDelay;
        reset = 1'b1;
        bot = '0;
        top = '0;
        botReq = 1'b0;
        resultAck = 1'b0;
        // First entry goes in right after reset
        setEntry(0, 16'h0000, 16'hFFFF, 0);
        setEntry(1, 16'h1234, 16'hFFFF, 2);
        setEntry(2, 16'h0000, 16'h0000, 0);
        setEntry(3, 16'h0080, 16'h0000, 1);
        // Set when at least two of x1..x3 are high
        setEntry(4, 16'hFCC0, 16'hFFFF, 0);
        setEntry(5, 16'hFCC0, 16'hFED4, 12);
        setEntry(6, 16'h8000, 16'h8000, 15);
        for (int n = 7; n < entryCount; n++) begin
            takeBits(16, r1);
            takeBits(16, r2);
            takeBits(16, r3);
            takeBits(3, r4);
            // Odd entries keep top above bot so some permutations pass
            setEntry(n, r1 & r2, (n % 2 == 1) ? ((r1 & r2) | r3) : r3, int'(r4));
        end
        maxDelay = 0;
        for (int n = 0; n < entryCount; n++) begin
            if (tableAckDelay[n] > maxDelay) maxDelay = tableAckDelay[n];
        end
        timeoutLimit = entryCount * (20 + maxDelay) + 50;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        offerEntry(0);
        for (int n = 0; n < entryCount; n++) begin
            applyEntry(n);
        end
        repeat (2) @(negedge clk);
        $display("Summary: %0d of %0d results seen, %0d errors",
            resultCount, entryCount, errorCount);
        if (errorCount == 0 && resultCount == entryCount) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// ==== tbChecker.sv ====
`timescale 1ns/100ps

module tbChecker
    import permPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        botAck,
    input  logic        resultReq,
    input  logic        resultAck,
    input  pcoeffSumT   pcoeffSum,
    input  pcoeffCountT pcoeffCount,
    output int          errorCount,
    output int          resultCount
);

    pcoeffSumT   sumQ [$];
    pcoeffCountT countQ [$];
    pcoeffSumT   wantSum;
    pcoeffCountT wantCount;
    logic        prevReq;
    logic        prevAck;
    logic        outActive;
    logic        fromReset;

    // Called by the stimulus before each bot is offered
    task automatic expectResult(input pcoeffSumT sum, input pcoeffCountT count);
        sumQ.push_back(sum);
        countQ.push_back(count);
    endtask

    task automatic compareValue(input string name, input int got, input int want);
        if (got != want) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    // Sampled on the rising edge, before the DUT updates
    always @(posedge clk) begin
        if (reset) begin
            errorCount = 0;
            resultCount = 0;
            prevReq = 1'b0;
            prevAck = 1'b0;
            outActive = 1'b0;
            fromReset = 1'b1;
        end else begin
            if (fromReset && (botAck || resultReq)) begin
                errorCount++;
                $display("Handshake outputs were not low after reset at %0t", $time);
            end
            fromReset = 1'b0;
            if (botAck && !prevAck && outActive) begin
                errorCount++;
                $display("botAck rose at %0t before the result handshake finished", $time);
            end
            if (resultReq && !prevReq) begin
                resultCount++;
                outActive = 1'b1;
                if (sumQ.size() == 0) begin
                    errorCount++;
                    $display("Result at %0t arrived with no expected values queued", $time);
                    wantSum = pcoeffSum;
                    wantCount = pcoeffCount;
                end else begin
                    wantSum = sumQ.pop_front();
                    wantCount = countQ.pop_front();
                end
            end
            // Data has to hold for as long as the request is up
            if (resultReq) begin
                compareValue("pcoeffSum", int'(pcoeffSum), int'(wantSum));
                compareValue("pcoeffCount", int'(pcoeffCount), int'(wantCount));
            end
            if (outActive && !resultReq && !resultAck) begin
                outActive = 1'b0;
                $display("Test %0d done: expected sum %0d count %0d, errors so far %0d",
                    resultCount, wantSum, wantCount, errorCount);
            end
            prevReq = resultReq;
            prevAck = botAck;
        end
    end

endmodule

// ==== permutationPipeline.sv ====
`timescale 1ns/100ps

`include "permPipe_defs.svh"

module permutationPipeline
    import permPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  botT         bot,
    input  botT         top,
    input  logic        botReq,
    output logic        botAck,
    output logic        resultReq,
    input  logic        resultAck,
    output pcoeffSumT   pcoeffSum,
    output pcoeffCountT pcoeffCount
);

    botT       heldBot;
    botT       heldTop;
    logic      start;
    logic      clear;
    permIndexT permIndex;
    logic      permValid;
    logic      lastPerm;
    botT       permutedBot;
    logic      permutedValid;
    logic      batchEnd;
    logic      batchDone;

    batchController controller_i (
        .clk(clk),
        .reset(reset),
        .botReq(botReq),
        .botAck(botAck),
        .bot(bot),
        .top(top),
        .heldBot(heldBot),
        .heldTop(heldTop),
        .start(start),
        .clear(clear),
        .batchDone(batchDone),
        .resultReq(resultReq),
        .resultAck(resultAck)
    );

    batchCounter counter_i (
        .clk(clk),
        .reset(reset),
        .start(start),
        .permIndex(permIndex),
        .permValid(permValid),
        .lastPerm(lastPerm)
    );

    variableSwapper swapper_i (
        .clk(clk),
        .reset(reset),
        .bot(heldBot),
        .permIndex(permIndex),
        .permValid(permValid),
        .permutedBot(permutedBot),
        .permutedValid(permutedValid)
    );

    // Last flag follows the swapper stages
    delayLine #(.T(logic), .stages(`SWAP_LATENCY)) lastPermDelay_i (
        .clk(clk),
        .reset(reset),
        .dataIn(lastPerm),
        .dataOut(batchEnd)
    );

    pcoeffAccumulator accumulator_i (
        .clk(clk),
        .reset(reset),
        .clear(clear),
        .top(heldTop),
        .permutedBot(permutedBot),
        .permutedValid(permutedValid),
        .batchEnd(batchEnd),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount),
        .batchDone(batchDone)
    );

endmodule

// ==== batchController.sv ====
`timescale 1ns/100ps

module batchController
    import permPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic botReq,
    output logic botAck,
    input  botT  bot,
    input  botT  top,
    output botT  heldBot,
    output botT  heldTop,
    output logic start,
    output logic clear,
    input  logic batchDone,
    output logic resultReq,
    input  logic resultAck
);

    ctrlStateT state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= Idle;
            botAck    <= 1'b0;
            resultReq <= 1'b0;
            start     <= 1'b0;
            clear     <= 1'b0;
        end else begin
            // Single-cycle pulses
            start <= 1'b0;
            clear <= 1'b0;
            case (state)
                Idle: begin
                    if (botReq) begin
                        botAck <= 1'b1;
                        start  <= 1'b1;
                        clear  <= 1'b1;
                        state  <= InAck;
                    end
                end
                InAck: begin
                    // Batch is already running here
                    if (!botReq) begin
                        botAck <= 1'b0;
                        if (batchDone) begin
                            resultReq <= 1'b1;
                            state     <= OutReq;
                        end else begin
                            state <= Run;
                        end
                    end else if (batchDone) begin
                        state <= Drain;
                    end
                end
                Drain: begin
                    // Result ready, input side still holding its request
                    if (!botReq) begin
                        botAck    <= 1'b0;
                        resultReq <= 1'b1;
                        state     <= OutReq;
                    end
                end
                Run: begin
                    if (batchDone) begin
                        resultReq <= 1'b1;
                        state     <= OutReq;
                    end
                end
                OutReq: begin
                    if (resultAck) begin
                        resultReq <= 1'b0;
                        state     <= OutWait;
                    end
                end
                OutWait: begin
                    if (!resultAck) begin
                        state <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // Operands held for the whole batch
    always_ff @(posedge clk) begin
        if (state == Idle && botReq) begin
            heldBot <= bot;
            heldTop <= top;
        end
    end

    // Drain is only ever entered on batchDone
    reqAfterDone: assert property (@(posedge clk) disable iff (reset)
        $rose(resultReq) |-> ($past(batchDone) || $past(state == Drain)));

    noAckInRun: assert property (@(posedge clk) disable iff (reset)
        (state == Run) |-> !botAck);

endmodule

// ==== pcoeffAccumulator.sv ====
`timescale 1ns/100ps

`include "permPipe_defs.svh"

module pcoeffAccumulator
    import permPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  botT         top,
    input  botT         permutedBot,
    input  logic        permutedValid,
    input  logic        batchEnd,
    output pcoeffSumT   pcoeffSum,
    output pcoeffCountT pcoeffCount,
    output logic        batchDone
);

    logic      isSubset;
    pcoeffSumT gap;

    // Valid when no 1-entry of the permuted bot lies outside top
    assign isSubset = (permutedBot & ~top) == '0;

    // Entries of top missing from the permuted bot
    assign gap = pcoeffSumT'($countones(top & ~permutedBot));

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            pcoeffSum   <= '0;
            pcoeffCount <= '0;
        end else if (permutedValid && isSubset) begin
            pcoeffSum   <= pcoeffSum + gap;
            pcoeffCount <= pcoeffCount + 1'b1;
        end
    end

    // Pulses with the final update of the batch
    always_ff @(posedge clk) begin
        if (reset) begin
            batchDone <= 1'b0;
        end else begin
            batchDone <= permutedValid && batchEnd;
        end
    end

    countInRange: assert property (@(posedge clk) disable iff (reset)
        pcoeffCount <= pcoeffCountT'(`PERM_COUNT));

    // The delayed last flag has to line up with the swapper output
    batchEndAligned: assert property (@(posedge clk) disable iff (reset)
        batchEnd |-> permutedValid);

endmodule

// ==== variableSwapper.sv ====
`timescale 1ns/100ps

`include "permPipe_defs.svh"

module variableSwapper
    import permPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  botT       bot,
    input  permIndexT permIndex,
    input  logic      permValid,
    output botT       permutedBot,
    output logic      permutedValid
);

    // Entry i of the result is f(x0, x_s1, x_s2, x_s3) at the inputs coded by i
    function automatic botT permuteBot(botT b, permIndexT k);
        logic [1:0] s1;
        logic [1:0] s2;
        logic [1:0] s3;
        logic [3:0] entry;
        logic [3:0] source;
        botT result;
        case (k)
            3'd1:    {s1, s2, s3} = {2'd1, 2'd3, 2'd2};
            3'd2:    {s1, s2, s3} = {2'd2, 2'd1, 2'd3};
            3'd3:    {s1, s2, s3} = {2'd2, 2'd3, 2'd1};
            3'd4:    {s1, s2, s3} = {2'd3, 2'd1, 2'd2};
            3'd5:    {s1, s2, s3} = {2'd3, 2'd2, 2'd1};
            default: {s1, s2, s3} = {2'd1, 2'd2, 2'd3};
        endcase
        for (int i = 0; i < `BOT_WIDTH; i++) begin
            entry = 4'(i);
            // x0 stays in bit 0
            source = {entry[s3], entry[s2], entry[s1], entry[0]};
            result[i] = b[source];
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            permutedValid <= 1'b0;
        end else begin
            permutedValid <= permValid;
        end
    end

    always_ff @(posedge clk) begin
        permutedBot <= permuteBot(bot, permIndex);
    end

endmodule

// ==== batchCounter.sv ====
`timescale 1ns/100ps

`include "permPipe_defs.svh"

module batchCounter
    import permPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    output permIndexT permIndex,
    output logic      permValid,
    output logic      lastPerm
);

    localparam permIndexT finalIndex = permIndexT'(`PERM_COUNT - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            permIndex <= '0;
            permValid <= 1'b0;
        end else if (start) begin
            permIndex <= '0;
            permValid <= 1'b1;
        end else if (permValid) begin
            // Stop after the final index, hold the index at rest
            if (permIndex == finalIndex) begin
                permValid <= 1'b0;
                permIndex <= '0;
            end else begin
                permIndex <= permIndex + 1'b1;
            end
        end
    end

    assign lastPerm = permValid && (permIndex == finalIndex);

    // Controller only restarts once the previous batch has been issued
    startWhileIdle: assert property (@(posedge clk) disable iff (reset) start |-> !permValid);

endmodule

// ==== delayLine.sv ====
`timescale 1ns/100ps

module delayLine #(
    parameter type T = logic,
    parameter int stages = 1
) (
    input  logic clk,
    input  logic reset,
    input  T     dataIn,
    output T     dataOut
);

    // Stage 0 takes the input, last stage drives the output
    T pipe [stages];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < stages; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= dataIn;
            for (int i = 1; i < stages; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dataOut = pipe[stages-1];

endmodule

// ==== permPkg.sv ====
`include "permPipe_defs.svh"

package permPkg;

    // Used for both bots and tops
    typedef logic [`BOT_WIDTH-1:0] botT;

    // Index into the permutation list, 0..PERM_COUNT-1
    typedef logic [$clog2(`PERM_COUNT)-1:0] permIndexT;

    // Max is 6 permutations times 16 entries
    typedef logic [7:0] pcoeffSumT;

    // Max is 6
    typedef logic [2:0] pcoeffCountT;

    // Batch controller states
    typedef enum logic [2:0] {
        Idle,
        InAck,
        Run,
        Drain,
        OutReq,
        OutWait
    } ctrlStateT;

endpackage

// ==== permPipe_defs.svh ====
`ifndef PERM_PIPE_DEFS_SVH
`define PERM_PIPE_DEFS_SVH

// Truth table of a 4-variable function
`define BOT_WIDTH 16

// Permutations of x1..x3 with x0 fixed
`define PERM_COUNT 6

// Register stages in variableSwapper
`define SWAP_LATENCY 1

// Register stages in pcoeffAccumulator
`define ACCUM_LATENCY 1

`endif
